// ==== snow_bus_pkg.sv ====
// snow bus shared types
// address map and port offsets

package snow_bus_pkg;

    // region a request decodes to
    typedef enum logic [2:0] {
        REGION_NONE   = 3'd0,
        REGION_WRAM   = 3'd1,
        REGION_PALRAM = 3'd2,
        REGION_VDP    = 3'd3,
        REGION_IO     = 3'd4
    } region_e;

    // vdp command window operations
    typedef enum logic [2:0] {
        VDP_NONE        = 3'd0,
        VDP_SELECT_REG  = 3'd1,
        VDP_WRITE_REG   = 3'd2,
        VDP_WRITE_RAM   = 3'd3,
        VDP_READ_RAM_H  = 3'd4,
        VDP_READ_RAM_L  = 3'd5,
        VDP_SET_RAM_PTR = 3'd6
    } vdp_op_e;

    // high byte-address fields per region
    localparam logic [7:0]  WRAM_BASE_HI   = 8'h10;   // 0x100000 - 0x10ffff
    localparam logic [3:0]  VDP_BASE_HI    = 4'h3;    // 0x300000 - 0x30000f
    localparam logic [3:0]  PALRAM_BASE_HI = 4'h4;    // 0x400000 - 0x400fff
    localparam logic [11:0] IO_BASE_HI     = 12'h700; // 0x700000 - 0x700fff

    // input port byte offsets inside the i/o window
    localparam logic [11:0] IO_JMPR = 12'h000;
    localparam logic [11:0] IO_DSWA = 12'h004;
    localparam logic [11:0] IO_DSWB = 12'h008;
    localparam logic [11:0] IO_IN1  = 12'h00C;
    localparam logic [11:0] IO_IN2  = 12'h010;
    localparam logic [11:0] IO_SYS  = 12'h01C;

    // default word-address widths
    localparam int WRAM_AW   = 15; // 32k words
    localparam int PALRAM_AW = 11; // 2k words

endpackage

// ==== bus_decode.sv ====
// bus request decode stage

`timescale 1ns/1ps

module bus_decode
    import snow_bus_pkg::*;
(
    input  logic        CLK96,
    input  logic        RESET96,
    input  logic        req_valid,
    input  logic [22:0] req_addr,   // word address, bits 23:1
    input  logic        req_write,
    input  logic [1:0]  req_be,
    input  logic [15:0] req_wdata,
    input  logic        dec_ready,
    output logic        req_ready,
    output logic        dec_valid,
    output region_e     dec_region,
    output vdp_op_e     dec_op,
    output logic [15:0] dec_offset,
    output logic        dec_write,
    output logic [1:0]  dec_be,
    output logic [15:0] dec_wdata
);

    logic [23:0] byte_addr;
    region_e     region_nxt;
    vdp_op_e     op_nxt;

    assign byte_addr = {req_addr, 1'b0}; // easier to follow the memory map
    assign req_ready = !dec_valid || dec_ready;

    always_comb begin
        region_nxt = REGION_NONE;
        op_nxt     = VDP_NONE;
        if (byte_addr[23:16] == WRAM_BASE_HI) begin
            region_nxt = REGION_WRAM;
        end else if (byte_addr[23:20] == PALRAM_BASE_HI) begin
            region_nxt = REGION_PALRAM;
        end else if (byte_addr[23:12] == IO_BASE_HI) begin
            region_nxt = REGION_IO;
        end else if (byte_addr[23:20] == VDP_BASE_HI && byte_addr[19:4] == '0) begin
            if (req_write) begin
                case (byte_addr[3:0])
                    4'hC:       op_nxt = VDP_WRITE_REG;
                    4'h8:       op_nxt = VDP_SELECT_REG;
                    4'h4, 4'h6: op_nxt = VDP_WRITE_RAM;
                    4'h0:       op_nxt = VDP_SET_RAM_PTR;
                    default:    op_nxt = VDP_NONE;
                endcase
            end else begin
                case (byte_addr[3:0])
                    4'h4:    op_nxt = VDP_READ_RAM_H;
                    4'h6:    op_nxt = VDP_READ_RAM_L;
                    default: op_nxt = VDP_NONE;
                endcase
            end
            // unknown window offsets fall through as unmapped
            if (op_nxt != VDP_NONE) begin
                region_nxt = REGION_VDP;
            end
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            dec_valid <= 1'b0;
        end else if (req_ready) begin
            dec_valid <= req_valid;
        end
    end

    always_ff @(posedge CLK96) begin
        if (req_valid && req_ready) begin
            dec_region <= region_nxt;
            dec_op     <= op_nxt;
            dec_offset <= req_addr[15:0];
            dec_write  <= req_write;
            dec_be     <= req_be;
            dec_wdata  <= req_wdata;
        end
    end

    // a stalled request must not change region under the execute stage
    a_region_stable: assert property (@(posedge CLK96) disable iff (RESET96)
        dec_valid && !dec_ready |=> $stable(dec_region))
        else $error("dec_region changed while stalled");

endmodule

// ==== dual_port_ram16.sv ====
// 16-bit word ram, byte writes

`timescale 1ns/1ps

module dual_port_ram16 #(
    parameter int AW = 11
) (
    input  logic          CLK96,
    input  logic [AW-1:0] a_addr,
    input  logic [1:0]    a_we,     // {upper, lower}
    input  logic [15:0]   a_wdata,
    input  logic [AW-1:0] b_addr,
    output logic [15:0]   a_rdata,
    output logic [15:0]   b_rdata
);

    logic [15:0] mem [0:(1<<AW)-1];

    always_ff @(posedge CLK96) begin
        if (a_we[1]) begin
            mem[a_addr][15:8] <= a_wdata[15:8];
        end
        if (a_we[0]) begin
            mem[a_addr][7:0] <= a_wdata[7:0];
        end
        a_rdata <= mem[a_addr]; // old word on a write cycle
    end

    // read-only port
    always_ff @(posedge CLK96) begin
        b_rdata <= mem[b_addr];
    end

endmodule

// ==== vdp_command.sv ====
// vdp operation holder

`timescale 1ns/1ps

module vdp_command
    import snow_bus_pkg::*;
(
    input  logic        CLK96,
    input  logic        RESET96,
    input  logic        start,
    input  vdp_op_e     op,
    input  logic [15:0] wdata,
    input  logic        vdp_ack,
    input  logic [15:0] vdp_rdata,
    output logic        vdp_valid,
    output vdp_op_e     vdp_op,
    output logic [15:0] vdp_wdata,
    output logic        done,
    output logic [15:0] rdata
);

    logic accepted;
    logic is_read;

    assign accepted = vdp_valid && vdp_ack;
    assign is_read  = (vdp_op == VDP_READ_RAM_H) || (vdp_op == VDP_READ_RAM_L);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            vdp_valid <= 1'b0;
            vdp_op    <= VDP_NONE;
            done      <= 1'b0;
        end else begin
            done <= accepted; // one pulse after the ack cycle
            if (start) begin
                vdp_valid <= 1'b1;
                vdp_op    <= op;
            end else if (accepted) begin
                vdp_valid <= 1'b0;
                vdp_op    <= VDP_NONE;
            end
        end
    end

    // payload, held while vdp_valid is up
    always_ff @(posedge CLK96) begin
        if (start) begin
            vdp_wdata <= wdata;
        end
    end

    always_ff @(posedge CLK96) begin
        if (accepted && is_read) begin
            rdata <= vdp_rdata;
        end
    end

    a_op_valid: assert property (@(posedge CLK96) disable iff (RESET96)
        vdp_valid |-> vdp_op != VDP_NONE)
        else $error("vdp_valid raised without an operation");

endmodule

// ==== bus_execute.sv ====
// bus execute stage
// ram, vdp and input port accesses

`timescale 1ns/1ps

module bus_execute
    import snow_bus_pkg::*;
#(
    parameter int WRAM_AW   = snow_bus_pkg::WRAM_AW,
    parameter int PALRAM_AW = snow_bus_pkg::PALRAM_AW
) (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  logic                 dec_valid,
    input  region_e              dec_region,
    input  vdp_op_e              dec_op,
    input  logic [15:0]          dec_offset,
    input  logic                 dec_write,
    input  logic [1:0]           dec_be,
    input  logic [15:0]          dec_wdata,
    input  logic                 exe_ready,
    input  logic [9:0]           joystick1,
    input  logic [9:0]           joystick2,
    input  logic [1:0]           start_button,
    input  logic [1:0]           coin_input,
    input  logic                 service,
    input  logic                 dip_test,
    input  logic [7:0]           dipsw_a,
    input  logic [7:0]           dipsw_b,
    input  logic [7:0]           dipsw_c,
    input  logic [PALRAM_AW-1:0] pal_addr,
    input  logic                 vdp_ack,
    input  logic [15:0]          vdp_rdata,
    output logic                 dec_ready,
    output logic                 exe_valid,
    output logic [15:0]          exe_rdata,
    output logic [15:0]          pal_data,
    output logic                 vdp_valid,
    output vdp_op_e              vdp_op,
    output logic [15:0]          vdp_wdata
);

    logic        handoff, acc_valid, acc_done, acc_write, vdp_done;
    region_e     acc_region;
    logic [11:0] acc_io_off;       // byte offset in the i/o window
    logic [1:0]  wram_we, pal_we;
    logic [15:0] wram_q, pal_q, vdp_q, io_word, rdata_nxt;
    logic [7:0]  p1_ctrl, p2_ctrl, sys_byte;

    assign handoff   = dec_valid && dec_ready;
    assign dec_ready = !acc_valid && (!exe_valid || exe_ready); // one request at a time
    assign acc_done  = acc_valid && (acc_region != REGION_VDP || vdp_done);
    assign wram_we   = (handoff && dec_write && dec_region == REGION_WRAM) ? dec_be : 2'b00;
    assign pal_we    = (handoff && dec_write && dec_region == REGION_PALRAM) ? dec_be : 2'b00;

    dual_port_ram16 #(.AW(WRAM_AW)) u_wram (
        .CLK96(CLK96), .a_addr(dec_offset[WRAM_AW-1:0]), .a_we(wram_we),
        .a_wdata(dec_wdata), .b_addr('0), .a_rdata(wram_q), .b_rdata()
    );

    dual_port_ram16 #(.AW(PALRAM_AW)) u_palram (
        .CLK96(CLK96), .a_addr(dec_offset[PALRAM_AW-1:0]), .a_we(pal_we),
        .a_wdata(dec_wdata), .b_addr(pal_addr), .a_rdata(pal_q), .b_rdata(pal_data)
    );

    vdp_command u_vdp_command (
        .CLK96(CLK96), .RESET96(RESET96), .start(handoff && dec_region == REGION_VDP),
        .op(dec_op), .wdata(dec_wdata), .vdp_ack(vdp_ack), .vdp_rdata(vdp_rdata),
        .vdp_valid(vdp_valid), .vdp_op(vdp_op), .vdp_wdata(vdp_wdata),
        .done(vdp_done), .rdata(vdp_q)
    );

    // controls are active low on the board
    assign p1_ctrl  = {1'b0, ~joystick1[5], ~joystick1[4], ~joystick1[0],
                       ~joystick1[1], ~joystick1[2], ~joystick1[3], 1'b0};
    assign p2_ctrl  = {1'b0, ~joystick2[5], ~joystick2[4], ~joystick2[0],
                       ~joystick2[1], ~joystick2[2], ~joystick2[3], 1'b0};
    assign sys_byte = {1'b0, ~start_button[1], ~start_button[0], ~coin_input[1],
                       ~coin_input[0], ~dip_test, 1'b0, ~service};

    always_comb begin
        case (acc_io_off)
            IO_IN1:  io_word = {2{p1_ctrl}};
            IO_IN2:  io_word = {2{p2_ctrl}};
            IO_SYS:  io_word = {2{sys_byte}};
            IO_DSWA: io_word = {2{dipsw_a}};
            IO_DSWB: io_word = {2{dipsw_b}};
            IO_JMPR: io_word = {2{dipsw_c}};
            default: io_word = 16'h0000;
        endcase
        if (acc_write) begin
            rdata_nxt = 16'h0000; // writes answer with zero
        end else begin
            case (acc_region)
                REGION_WRAM:   rdata_nxt = wram_q;
                REGION_PALRAM: rdata_nxt = pal_q;
                REGION_VDP:    rdata_nxt = vdp_q;
                REGION_IO:     rdata_nxt = io_word;
                default:       rdata_nxt = 16'h0000;
            endcase
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            acc_valid <= 1'b0;
            exe_valid <= 1'b0;
        end else begin
            if (handoff) acc_valid <= 1'b1;
            else if (acc_done) acc_valid <= 1'b0;
            if (acc_done) exe_valid <= 1'b1;
            else if (exe_ready) exe_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK96) begin
        if (handoff) begin
            acc_region <= dec_region;
            acc_write  <= dec_write;
            acc_io_off <= {dec_offset[10:0], 1'b0};
        end
        if (acc_done) begin
            exe_rdata <= rdata_nxt;
        end
    end

endmodule

// ==== bus_response.sv ====
// bus response register

`timescale 1ns/1ps

module bus_response (
    input  logic        CLK96,
    input  logic        RESET96,
    input  logic        exe_valid,
    input  logic [15:0] exe_rdata,
    input  logic        rsp_ready,
    output logic        exe_ready,
    output logic        rsp_valid,
    output logic [15:0] rsp_rdata
);

    // empty, or the word leaves this cycle
    assign exe_ready = !rsp_valid || rsp_ready;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            rsp_valid <= 1'b0;
        end else if (exe_ready) begin
            rsp_valid <= exe_valid;
        end
    end

    always_ff @(posedge CLK96) begin
        if (exe_valid && exe_ready) begin
            rsp_rdata <= exe_rdata;
        end
    end

    // requester sees a steady word during back-pressure
    a_rdata_stable: assert property (@(posedge CLK96) disable iff (RESET96)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
        else $error("rsp_rdata changed while stalled");

endmodule

// ==== snow_bus_ctrl.sv ====
// snow bus controller
// request decode, execute and response

`timescale 1ns/1ps

module snow_bus_ctrl
    import snow_bus_pkg::*;
#(
    parameter int WRAM_AW   = snow_bus_pkg::WRAM_AW,
    parameter int PALRAM_AW = snow_bus_pkg::PALRAM_AW
) (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  logic                 req_valid,
    input  logic [22:0]          req_addr,
    input  logic                 req_write,
    input  logic [1:0]           req_be,
    input  logic [15:0]          req_wdata,
    output logic                 req_ready,
    output logic                 rsp_valid,
    output logic [15:0]          rsp_rdata,
    input  logic                 rsp_ready,
    output logic                 vdp_valid,
    output vdp_op_e              vdp_op,
    output logic [15:0]          vdp_wdata,
    input  logic                 vdp_ack,
    input  logic [15:0]          vdp_rdata,
    input  logic [9:0]           joystick1,
    input  logic [9:0]           joystick2,
    input  logic [1:0]           start_button,
    input  logic [1:0]           coin_input,
    input  logic                 service,
    input  logic                 dip_test,
    input  logic [7:0]           dipsw_a,
    input  logic [7:0]           dipsw_b,
    input  logic [7:0]           dipsw_c,
    input  logic [PALRAM_AW-1:0] pal_addr,
    output logic [15:0]          pal_data
);

    // decode to execute
    logic        dec_valid, dec_ready, dec_write;
    region_e     dec_region;
    vdp_op_e     dec_op;
    logic [15:0] dec_offset, dec_wdata;
    logic [1:0]  dec_be;

    // execute to response
    logic        exe_valid, exe_ready;
    logic [15:0] exe_rdata;

    bus_decode u_decode (
        .CLK96(CLK96), .RESET96(RESET96),
        .req_valid(req_valid), .req_addr(req_addr), .req_write(req_write),
        .req_be(req_be), .req_wdata(req_wdata), .dec_ready(dec_ready),
        .req_ready(req_ready), .dec_valid(dec_valid), .dec_region(dec_region),
        .dec_op(dec_op), .dec_offset(dec_offset), .dec_write(dec_write),
        .dec_be(dec_be), .dec_wdata(dec_wdata)
    );

    bus_execute #(.WRAM_AW(WRAM_AW), .PALRAM_AW(PALRAM_AW)) u_execute (
        .CLK96(CLK96), .RESET96(RESET96),
        .dec_valid(dec_valid), .dec_region(dec_region), .dec_op(dec_op),
        .dec_offset(dec_offset), .dec_write(dec_write), .dec_be(dec_be),
        .dec_wdata(dec_wdata), .exe_ready(exe_ready),
        .joystick1(joystick1), .joystick2(joystick2), .start_button(start_button),
        .coin_input(coin_input), .service(service), .dip_test(dip_test),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b), .dipsw_c(dipsw_c),
        .pal_addr(pal_addr), .vdp_ack(vdp_ack), .vdp_rdata(vdp_rdata),
        .dec_ready(dec_ready), .exe_valid(exe_valid), .exe_rdata(exe_rdata),
        .pal_data(pal_data), .vdp_valid(vdp_valid), .vdp_op(vdp_op),
        .vdp_wdata(vdp_wdata)
    );

    bus_response u_response (
        .CLK96(CLK96), .RESET96(RESET96),
        .exe_valid(exe_valid), .exe_rdata(exe_rdata), .rsp_ready(rsp_ready),
        .exe_ready(exe_ready), .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata)
    );

endmodule

// ==== tb_snow_bus_ctrl.sv ====
// snow bus controller testbench

`timescale 1ns/1ps

module tb_snow_bus_ctrl
    import snow_bus_pkg::*;
;

    logic        CLK96, RESET96;
    logic        req_valid, req_write, req_ready;
    logic [22:0] req_addr;
    logic [1:0]  req_be;
    logic [15:0] req_wdata;
    logic        rsp_valid;
    logic        rsp_ready = 1'b1;
    logic [15:0] rsp_rdata;
    logic        vdp_valid;
    logic        vdp_ack = 1'b0;
    vdp_op_e     vdp_op;
    logic [15:0] vdp_wdata;
    logic [15:0] vdp_rdata = '0;
    logic [9:0]  joystick1, joystick2;
    logic [1:0]  start_button, coin_input;
    logic        service, dip_test;
    logic [7:0]  dipsw_a, dipsw_b, dipsw_c;
    logic [10:0] pal_addr;
    logic [15:0] pal_data;

    logic [31:0] seed = 32'hea3b4051;
    int          errors = 0;
    int          timeouts = 0;
    logic        bp_en = 1'b0;
    int          accepted_cnt = 0; // requests taken by the DUT

    // expected responses and vdp episodes in order
    logic [15:0] exp_mem [0:255];
    logic [7:0]  wr_ptr = 8'd0;
    logic [7:0]  rd_ptr = 8'd0;
    vdp_op_e     vop_exp [0:255];
    logic [15:0] vwd_exp [0:255];
    logic [15:0] vval    [0:255];
    logic [7:0]  vwr = 8'd0;
    logic [7:0]  vep = 8'd0;
    int          vdly = 0;

    logic [15:0] wram_sh [0:15];  // shadow of the words in use
    logic        pal_chk, pal_chk_d;
    logic [15:0] pal_exp, pal_exp_d;

    snow_bus_ctrl #(.WRAM_AW(15), .PALRAM_AW(11)) snow_bus_ctrl_i (.*);

    always #50 CLK96 = ~CLK96;

    function automatic logic [31:0] rnd();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [7:0] ctrl_byte(input logic [9:0] j);
        return {1'b0, ~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3], 1'b0};
    endfunction

    function automatic logic [15:0] io_expect(input logic [11:0] off);
        logic [7:0] b;
        case (off)
            12'h00C: b = ctrl_byte(joystick1);
            12'h010: b = ctrl_byte(joystick2);
            12'h01C: b = {1'b0, ~start_button, ~coin_input, ~dip_test, 1'b0, ~service};
            12'h004: b = dipsw_a;
            12'h008: b = dipsw_b;
            12'h000: b = dipsw_c;
            default: b = 8'h00;
        endcase
        return {b, b};
    endfunction

    always @(posedge CLK96) begin
        if (req_valid && req_ready) accepted_cnt <= accepted_cnt + 1;
        if (rsp_valid && rsp_ready) rd_ptr <= rd_ptr + 8'd1;
        if (vdp_valid && vdp_ack) vep <= vep + 8'd1;
        pal_chk_d <= pal_chk;
        pal_exp_d <= pal_exp;
    end

    // vdp model with a random ack delay
    always @(negedge CLK96) begin
        if (vdp_ack) begin
            vdp_ack <= 1'b0; // the ack edge has passed
        end else if (vdp_valid) begin
            if (vdly == 0) begin
                vdp_ack   <= 1'b1;
                vdp_rdata <= vval[vep];
                vdly      = int'(rnd() % 6);
            end else begin
                vdly = vdly - 1;
            end
        end
    end

    always @(negedge CLK96) begin
        rsp_ready <= bp_en ? 1'(rnd() >> 9) : 1'b1;
    end

    a_reset_state: assert property (@(posedge CLK96) $fell(RESET96) |->
        !rsp_valid && !vdp_valid && req_ready)
        else begin
            errors++;
            $display("reset state wrong after RESET96 fell");
        end

    a_rsp_order: assert property (@(posedge CLK96) disable iff (RESET96)
        rsp_valid && rsp_ready |-> rd_ptr != wr_ptr && rsp_rdata == exp_mem[rd_ptr])
        else begin
            errors++;
            $display("Mismatch at %0t: rsp_rdata got %h expected %h",
                $time, $sampled(rsp_rdata), $sampled(exp_mem[rd_ptr]));
        end

    a_rsp_hold: assert property (@(posedge CLK96) disable iff (RESET96)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
        else begin
            errors++;
            $display("response changed while stalled at %0t", $time);
        end

    a_vdp_op: assert property (@(posedge CLK96) disable iff (RESET96)
        vdp_valid && vdp_ack |-> vdp_op == vop_exp[vep])
        else begin
            errors++;
            $display("Mismatch at %0t: vdp_op got %0d expected %0d",
                $time, $sampled(vdp_op), $sampled(vop_exp[vep]));
        end

    a_vdp_wdata: assert property (@(posedge CLK96) disable iff (RESET96)
        vdp_valid && vdp_ack |-> vdp_wdata == vwd_exp[vep])
        else begin
            errors++;
            $display("Mismatch at %0t: vdp_wdata got %h expected %h",
                $time, $sampled(vdp_wdata), $sampled(vwd_exp[vep]));
        end

    a_vdp_hold: assert property (@(posedge CLK96) disable iff (RESET96)
        vdp_valid && !vdp_ack |=> vdp_valid && $stable(vdp_op) && $stable(vdp_wdata))
        else begin
            errors++;
            $display("vdp command dropped or changed before ack");
        end

    a_vdp_once: assert property (@(posedge CLK96) disable iff (RESET96)
        vdp_valid && vdp_ack |=> !vdp_valid)
        else begin
            errors++;
            $display("second vdp_valid episode for one request");
        end

    a_pal_video: assert property (@(posedge CLK96) pal_chk_d |-> pal_data == pal_exp_d)
        else begin
            errors++;
            $display("Mismatch at %0t: pal_data got %h expected %h",
                $time, $sampled(pal_data), $sampled(pal_exp_d));
        end

    task automatic finish_run();
        $display("errors: %0d checks failed, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // later waits are skipped once one has timed out
    task automatic timed_out(input string what);
        timeouts++;
        $display("timeout at %0t waiting for %s", $time, what);
    endtask

    task automatic issue(input logic [23:0] baddr, input logic wr, input logic [1:0] be,
                         input logic [15:0] wd, input logic [15:0] expv);
        int t = 0;
        int n0 = accepted_cnt;
        exp_mem[wr_ptr] = expv;
        wr_ptr    = wr_ptr + 8'd1;
        req_valid = 1'b1;
        req_addr  = baddr[23:1];
        req_write = wr;
        req_be    = be;
        req_wdata = wd;
        while (accepted_cnt == n0 && t < 200 && timeouts == 0) begin
            @(negedge CLK96);
            t++;
        end
        if (accepted_cnt == n0 && timeouts == 0) timed_out("req_ready");
        req_valid = 1'b0;
    endtask

    task automatic wram_access(input logic [3:0] idx, input logic wr);
        logic [15:0] d;
        logic [1:0]  be;
        d  = 16'(rnd() >> 8);
        be = wr ? 2'(rnd() >> 16) : 2'b11;
        if (wr) begin
            if (be[1]) wram_sh[idx][15:8] = d[15:8];
            if (be[0]) wram_sh[idx][7:0] = d[7:0];
        end
        issue(24'h100000 + {idx, 9'h0, 1'b0} * 24'd3, wr, be, d, wr ? 16'h0 : wram_sh[idx]);
    endtask

    task automatic vdp_access(input logic [3:0] off, input logic wr, input vdp_op_e op);
        logic [15:0] d;
        logic [15:0] v;
        d = 16'(rnd() >> 16);
        v = 16'(rnd() >> 8);
        if (op != VDP_NONE) begin
            vop_exp[vwr] = op;
            vwd_exp[vwr] = d;
            vval[vwr]    = v;
            vwr          = vwr + 8'd1;
        end
        issue({20'h30000, off}, wr, 2'b11, d, (wr || op == VDP_NONE) ? 16'h0 : v);
    endtask

    task automatic vdp_pick(input int k);
        case (k)
            0: vdp_access(4'h4, 1'b0, VDP_READ_RAM_H);
            1: vdp_access(4'h6, 1'b0, VDP_READ_RAM_L);
            2: vdp_access(4'hC, 1'b1, VDP_WRITE_REG);
            3: vdp_access(4'h8, 1'b1, VDP_SELECT_REG);
            4: vdp_access(4'h4, 1'b1, VDP_WRITE_RAM);
            5: vdp_access(4'h6, 1'b1, VDP_WRITE_RAM);
            6: vdp_access(4'h0, 1'b1, VDP_SET_RAM_PTR);
            default: vdp_access(4'h2, 1'b0, VDP_NONE); // hole in the window
        endcase
    endtask

    task automatic io_read(input logic [11:0] off);
        issue({12'h700, off}, 1'b0, 2'b11, 16'h0, io_expect(off));
    endtask

    task automatic wait_idle();
        int t = 0;
        while ((rd_ptr != wr_ptr || vep != vwr) && t < 2000 && timeouts == 0) begin
            @(negedge CLK96);
            t++;
        end
        if ((rd_ptr != wr_ptr || vep != vwr) && timeouts == 0) begin
            timed_out("responses to drain");
        end
    endtask

    initial begin
        logic [15:0] pd [0:3];
        CLK96 = 1'b0;
        RESET96 = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_write = 1'b0;
        req_be = 2'b00;
        req_wdata = '0;
        joystick1 = '0;
        joystick2 = '0;
        start_button = '0;
        coin_input = '0;
        service = 1'b0;
        dip_test = 1'b0;
        dipsw_a = '0;
        dipsw_b = '0;
        dipsw_c = '0;
        pal_addr = '0;
        pal_chk = 1'b0;
        pal_exp = '0;
        repeat (2) @(negedge CLK96);
        RESET96 = 1'b0;
        @(negedge CLK96);

        // work ram fill then random byte writes and reads
        for (int i = 0; i < 16; i++) begin
            wram_sh[i] = 16'(rnd());
            issue(24'h100000 + {i[3:0], 9'h0, 1'b0} * 24'd3, 1'b1, 2'b11, wram_sh[i], 16'h0);
        end
        for (int i = 0; i < 48; i++) wram_access(4'(rnd() >> 8), 1'(rnd() >> 4));
        wait_idle();

        // palette bus side then video side
        for (int i = 0; i < 4; i++) begin
            pd[i] = 16'(rnd() >> 12);
            issue(24'h400000 + 24'(i * 'h2A6), 1'b1, 2'b11, pd[i], 16'h0);
            issue(24'h400000 + 24'(i * 'h2A6), 1'b0, 2'b11, 16'h0, pd[i]);
        end
        wait_idle();
        for (int i = 0; i < 4; i++) begin
            pal_addr = 11'(i * 'h153);
            pal_exp  = pd[i];
            pal_chk  = 1'b1;
            repeat (2) @(negedge CLK96);
        end
        pal_chk = 1'b0;

        // input ports
        joystick1 = 10'(rnd());
        joystick2 = 10'(rnd() >> 10);
        start_button = 2'(rnd());
        coin_input = 2'(rnd() >> 2);
        service = 1'(rnd() >> 5);
        dip_test = 1'(rnd() >> 6);
        dipsw_a = 8'(rnd());
        dipsw_b = 8'(rnd() >> 8);
        dipsw_c = 8'(rnd() >> 16);
        io_read(12'h00C);
        io_read(12'h010);
        io_read(12'h01C);
        io_read(12'h004);
        io_read(12'h008);
        io_read(12'h000);
        io_read(12'h002);
        io_read(12'h020);
        issue({12'h700, 12'h00C}, 1'b1, 2'b11, 16'hBEEF, 16'h0);
        issue(24'h200000, 1'b0, 2'b11, 16'h0, 16'h0);  // unmapped
        issue(24'h500010, 1'b0, 2'b11, 16'h0, 16'h0);

        // every vdp offset and direction
        for (int k = 0; k < 8; k++) vdp_pick(k);
        wait_idle();

        // random mix under back-pressure
        bp_en = 1'b1;
        for (int i = 0; i < 60; i++) begin
            case (2'(rnd() >> 12))
                2'd0: wram_access(4'(rnd() >> 8), 1'(rnd() >> 4));
                2'd1: io_read(12'(rnd()) & 12'h01C);
                2'd2: vdp_pick(int'(3'(rnd() >> 16)));
                default: issue(24'h600000, 1'(rnd() >> 3), 2'b11, 16'h1234, 16'h0);
            endcase
        end
        wait_idle();
        bp_en = 1'b0;
        repeat (4) @(negedge CLK96);

        assert (rd_ptr == wr_ptr && vep == vwr)
            else begin
                errors++;
                $display("response or vdp episode count wrong");
            end
        finish_run();
    end

endmodule

// ==== snow_bus_ctrl.f ====
snow_bus_pkg.sv
bus_decode.sv
dual_port_ram16.sv
vdp_command.sv
bus_execute.sv
bus_response.sv
snow_bus_ctrl.sv
tb_snow_bus_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the snow bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_snow_bus_ctrl \
    -f snow_bus_ctrl.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1
